// File: tawas_pkg.sv
package tawas_pkg;

    // ####################
    // core dimensions.
    localparam int THREADS   = 4;   // also the pipeline depth.
    localparam int THREAD_W  = 2;
    localparam int REGS      = 8;
    localparam int REG_W     = 3;
    localparam int PC_W      = 24;
    localparam int PC_STRIDE = 256; // thread t starts at t * 256.

    // instruction class, bits 31:30.
    localparam logic [1:0] CLS_AU  = 2'd0;
    localparam logic [1:0] CLS_LS  = 2'd1;
    localparam logic [1:0] CLS_IMM = 2'd2;
    localparam logic [1:0] CLS_BR  = 2'd3;

    localparam logic [2:0] OP_ADD = 3'd0;
    localparam logic [2:0] OP_SUB = 3'd1;
    localparam logic [2:0] OP_AND = 3'd2;
    localparam logic [2:0] OP_OR  = 3'd3;
    localparam logic [2:0] OP_XOR = 3'd4;
    localparam logic [2:0] OP_SHL = 3'd5;  // by one.
    localparam logic [2:0] OP_SHR = 3'd6;  // by one, logical.
    localparam logic [2:0] OP_MOV = 3'd7;

    // ####################
    // instruction views, class always in 31:30.
    typedef struct packed {
        logic [1:0]       cls;
        logic [2:0]       opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] ra;
        logic [REG_W-1:0] rb;
        logic [17:0]      unused;
    } tawas_au_instr_t;

    typedef struct packed {
        logic [1:0]       cls;
        logic             store;
        logic [REG_W-1:0] rd;      // data register.
        logic [REG_W-1:0] ra;      // base register.
        logic [6:0]       unused;
        logic [15:0]      offset;  // signed.
    } tawas_ls_instr_t;

    typedef struct packed {
        logic [1:0]       cls;
        logic [REG_W-1:0] rd;
        logic [26:0]      imm;     // signed.
    } tawas_imm_instr_t;

    typedef struct packed {
        logic [1:0]      cls;
        logic            cond;     // taken only on zero flag.
        logic [4:0]      unused;
        logic [PC_W-1:0] target;
    } tawas_br_instr_t;

    typedef union packed {
        tawas_au_instr_t  au;
        tawas_ls_instr_t  ls;
        tawas_imm_instr_t imm;
        tawas_br_instr_t  br;
    } tawas_instr_u;

    // ####################
    // pipeline records.
    typedef struct packed {
        logic                valid;
        logic [THREAD_W-1:0] thread;
        logic [1:0]          cls;
        logic [2:0]          opcode;
        logic                store;
        logic [REG_W-1:0]    rd;
        logic [REG_W-1:0]    ra;
        logic [REG_W-1:0]    rb;
        logic [31:0]         imm;  // offset or load-immediate value.
    } tawas_op_t;

    typedef struct packed {
        logic [31:0] ra;
        logic [31:0] rb;
    } tawas_rd_data_t;

    typedef struct packed {
        logic                en;
        logic [THREAD_W-1:0] thread;
        logic [REG_W-1:0]    rd;
        logic [31:0]         data;
        logic                flag_en;
        logic                zero;
    } tawas_wb_t;

endpackage

// File: tawas_fetch.sv
module tawas_fetch (
    input  logic                             clk,
    input  logic                             rst_n,

    output logic                             ics,
    output logic [tawas_pkg::PC_W-1:0]       iaddr,
    input  logic [31:0]                      idata,

    input  logic                             zero_flag,
    output logic [tawas_pkg::THREAD_W-1:0]   rd_thread,
    output logic [tawas_pkg::REG_W-1:0]      ra_idx,
    output logic [tawas_pkg::REG_W-1:0]      rb_idx,

    output tawas_pkg::tawas_op_t             ex_op
);
    logic                           fetch_en;
    logic [tawas_pkg::THREAD_W-1:0] f_thread;   // thread being fetched.
    logic                           d_valid;
    logic [tawas_pkg::THREAD_W-1:0] d_thread;   // thread being decoded.
    logic [tawas_pkg::PC_W-1:0]     pc [tawas_pkg::THREADS];
    tawas_pkg::tawas_instr_u        instr;
    tawas_pkg::tawas_op_t           dec_op;
    logic                           br_taken;

    assign ics = fetch_en;
    assign iaddr = pc[f_thread];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
            f_thread <= '0;
            d_valid <= 1'b0;
            d_thread <= '0;
        end else begin
            fetch_en <= 1'b1;  // one idle cycle out of reset.
            if (fetch_en)
                f_thread <= f_thread + 1'b1;
            d_valid <= fetch_en;
            d_thread <= f_thread;
        end
    end

    // fetch and decode never touch the same thread's pc in one cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < tawas_pkg::THREADS; t++)
                pc[t] <= tawas_pkg::PC_W'(t * tawas_pkg::PC_STRIDE);
        end else begin
            if (fetch_en)
                pc[f_thread] <= pc[f_thread] + 1'b1;
            if (br_taken)
                pc[d_thread] <= instr.br.target;
        end
    end

    // ####################
    // decode.
    assign instr = idata;
    assign br_taken = d_valid && (instr.br.cls == tawas_pkg::CLS_BR) &&
                      (!instr.br.cond || zero_flag);

    always_comb begin
        dec_op = '0;
        dec_op.valid = d_valid;
        dec_op.thread = d_thread;
        dec_op.cls = instr.au.cls;
        case (instr.au.cls)
            tawas_pkg::CLS_AU: begin
                dec_op.opcode = instr.au.opcode;
                dec_op.rd = instr.au.rd;
                dec_op.ra = instr.au.ra;
                dec_op.rb = instr.au.rb;
            end
            tawas_pkg::CLS_LS: begin
                dec_op.store = instr.ls.store;
                dec_op.rd = instr.ls.rd;
                dec_op.ra = instr.ls.ra;
                dec_op.rb = instr.ls.rd;  // store data rides the rb port.
                dec_op.imm = {{16{instr.ls.offset[15]}}, instr.ls.offset};
            end
            tawas_pkg::CLS_IMM: begin
                dec_op.rd = instr.imm.rd;
                dec_op.imm = {{5{instr.imm.imm[26]}}, instr.imm.imm};
            end
            default: ;  // branch resolves here.
        endcase
    end

    assign rd_thread = d_thread;
    assign ra_idx = dec_op.ra;
    assign rb_idx = dec_op.rb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_op <= '0;
        else
            ex_op <= dec_op;
    end

    // execute always trails decode by exactly one slot of the rotation.
    a_rotation: assert property (@(posedge clk) disable iff (!rst_n)
        ex_op.valid |-> (d_valid && (ex_op.thread + 1'b1 == d_thread)));

endmodule

// File: tawas_regfile.sv
module tawas_regfile (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic [tawas_pkg::THREAD_W-1:0]   rd_thread,
    input  logic [tawas_pkg::REG_W-1:0]      ra_idx,
    input  logic [tawas_pkg::REG_W-1:0]      rb_idx,
    output tawas_pkg::tawas_rd_data_t        rd_data,
    output logic                             zero_flag,

    input  tawas_pkg::tawas_wb_t             au_wb,
    input  tawas_pkg::tawas_wb_t             ls_wb
);
    logic [31:0]                  regs [tawas_pkg::THREADS][tawas_pkg::REGS];
    logic [tawas_pkg::THREADS-1:0] zflag;
    tawas_pkg::tawas_wb_t         wb;

    assign zero_flag = zflag[rd_thread];  // for branches in decode.

    // operands land in the execute stage alongside ex_op.
    always_ff @(posedge clk) begin
        rd_data.ra <= regs[rd_thread][ra_idx];
        rd_data.rb <= regs[rd_thread][rb_idx];
    end

    // ####################
    // writeback.
    assign wb = au_wb.en ? au_wb : ls_wb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < tawas_pkg::THREADS; t++) begin
                for (int r = 0; r < tawas_pkg::REGS; r++)
                    regs[t][r] <= '0;
            end
            zflag <= '0;
        end else begin
            if (wb.en)
                regs[wb.thread][wb.rd] <= wb.data;
            if (wb.en && wb.flag_en)
                zflag[wb.thread] <= wb.zero;
        end
    end

    // au and ls retire in the same stage, so the class keeps them apart.
    a_one_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !(au_wb.en && ls_wb.en));

endmodule

// File: tawas_au.sv
module tawas_au (
    input  logic                       clk,
    input  logic                       rst_n,

    input  tawas_pkg::tawas_op_t       ex_op,
    input  tawas_pkg::tawas_rd_data_t  rd_data,

    output tawas_pkg::tawas_wb_t       au_wb
);
    logic        is_au;
    logic        is_imm;
    logic [31:0] result;

    assign is_au = ex_op.valid && (ex_op.cls == tawas_pkg::CLS_AU);
    assign is_imm = ex_op.valid && (ex_op.cls == tawas_pkg::CLS_IMM);

    // ####################
    // execute.
    always_comb begin
        result = ex_op.imm;  // load-immediate passes through.
        if (ex_op.cls == tawas_pkg::CLS_AU) begin
            case (ex_op.opcode)
                tawas_pkg::OP_ADD: result = rd_data.ra + rd_data.rb;
                tawas_pkg::OP_SUB: result = rd_data.ra - rd_data.rb;
                tawas_pkg::OP_AND: result = rd_data.ra & rd_data.rb;
                tawas_pkg::OP_OR:  result = rd_data.ra | rd_data.rb;
                tawas_pkg::OP_XOR: result = rd_data.ra ^ rd_data.rb;
                tawas_pkg::OP_SHL: result = {rd_data.ra[30:0], 1'b0};
                tawas_pkg::OP_SHR: result = {1'b0, rd_data.ra[31:1]};
                default:           result = rd_data.ra;  // move.
            endcase
        end
    end

    // result retires in the following cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            au_wb <= '0;
        end else begin
            au_wb.en <= is_au || is_imm;
            au_wb.thread <= ex_op.thread;
            au_wb.rd <= ex_op.rd;
            au_wb.data <= result;
            au_wb.flag_en <= is_au;  // immediates leave the flag alone.
            au_wb.zero <= (result == 32'd0);
        end
    end

endmodule

// File: tawas_ls.sv
module tawas_ls (
    input  logic                       clk,
    input  logic                       rst_n,

    input  tawas_pkg::tawas_op_t       ex_op,
    input  tawas_pkg::tawas_rd_data_t  rd_data,

    output logic                       dcs,
    output logic                       dwr,
    output logic [31:0]                daddr,
    output logic [31:0]                dout,
    input  logic [31:0]                din,

    output tawas_pkg::tawas_wb_t       ls_wb
);
    logic                           is_ls;
    logic                           ld_en;
    logic [tawas_pkg::THREAD_W-1:0] ld_thread;
    logic [tawas_pkg::REG_W-1:0]    ld_rd;

    assign is_ls = ex_op.valid && (ex_op.cls == tawas_pkg::CLS_LS);

    // ####################
    // data bus.
    assign dcs = is_ls;
    assign dwr = is_ls && ex_op.store;
    assign daddr = rd_data.ra + ex_op.imm;  // base plus signed offset.
    assign dout = rd_data.rb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ld_en <= 1'b0;
        else
            ld_en <= is_ls && !ex_op.store;
    end

    always_ff @(posedge clk) begin
        ld_thread <= ex_op.thread;
        ld_rd <= ex_op.rd;
    end

    // din is valid the cycle after dcs.
    always_comb begin
        ls_wb.en = ld_en;
        ls_wb.thread = ld_thread;
        ls_wb.rd = ld_rd;
        ls_wb.data = din;
        ls_wb.flag_en = 1'b0;  // loads leave the flag alone.
        ls_wb.zero = 1'b0;
    end

endmodule

// File: tawas.sv
module tawas (
    input  logic                        clk,
    input  logic                        rst_n,

    output logic                        ics,
    output logic [tawas_pkg::PC_W-1:0]  iaddr,
    input  logic [31:0]                 idata,

    output logic                        dcs,
    output logic                        dwr,
    output logic [31:0]                 daddr,
    output logic [31:0]                 dout,
    input  logic [31:0]                 din
);
    logic [tawas_pkg::THREAD_W-1:0] rd_thread;
    logic [tawas_pkg::REG_W-1:0]    ra_idx;
    logic [tawas_pkg::REG_W-1:0]    rb_idx;
    logic                           zero_flag;
    tawas_pkg::tawas_op_t           ex_op;
    tawas_pkg::tawas_rd_data_t      rd_data;
    tawas_pkg::tawas_wb_t           au_wb;
    tawas_pkg::tawas_wb_t           ls_wb;

    tawas_fetch tawas_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .ics(ics),
        .iaddr(iaddr),
        .idata(idata),
        .zero_flag(zero_flag),
        .rd_thread(rd_thread),
        .ra_idx(ra_idx),
        .rb_idx(rb_idx),
        .ex_op(ex_op)
    );

    tawas_regfile tawas_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rd_thread(rd_thread),
        .ra_idx(ra_idx),
        .rb_idx(rb_idx),
        .rd_data(rd_data),
        .zero_flag(zero_flag),
        .au_wb(au_wb),
        .ls_wb(ls_wb)
    );

    tawas_au tawas_au (
        .clk(clk),
        .rst_n(rst_n),
        .ex_op(ex_op),
        .rd_data(rd_data),
        .au_wb(au_wb)
    );

    tawas_ls tawas_ls (
        .clk(clk),
        .rst_n(rst_n),
        .ex_op(ex_op),
        .rd_data(rd_data),
        .dcs(dcs),
        .dwr(dwr),
        .daddr(daddr),
        .dout(dout),
        .din(din),
        .ls_wb(ls_wb)
    );

endmodule

// File: tb_tawas.sv
module tb_tawas;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_PC = 256;  // fetches kept per thread.
    localparam int MAX_ST = 64;   // stores kept per thread.

    logic        clk;
    logic        rst_n;
    logic        ics;
    logic [23:0] iaddr;
    logic [31:0] idata;
    logic        dcs;
    logic        dwr;
    logic [31:0] daddr;
    logic [31:0] dout;
    logic [31:0] din;

    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] lfsr;
    int          prog_pos;
    logic [23:0] pc_list [4][MAX_PC];
    int          pc_cnt [4];
    int          pc_idx [4];
    logic        halted [4];
    logic [31:0] st_addr [4][MAX_ST];
    logic [31:0] st_data [4][MAX_ST];
    int          st_cnt [4];
    int          st_idx [4];
    int          fcount;
    int          fth;
    int          sth;
    logic        ipend;
    logic [9:0]  ipend_addr;
    logic        dpend;
    logic [7:0]  dpend_addr;
    string       test_name;
    logic        quiet_bus;
    int          errors;
    int          tests;
    int          failed;
    int          limit;
    int          wd_cycles;

    tawas DUT (.*);

    always #20 clk = ~clk;

    // ####################
    // stimulus helpers.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_au(input logic [2:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [2:0] rb);
        tawas_pkg::tawas_instr_u w;
        w = '0;
        w.au.cls = tawas_pkg::CLS_AU;
        w.au.opcode = op;
        w.au.rd = rd;
        w.au.ra = ra;
        w.au.rb = rb;
        return w;
    endfunction

    function automatic logic [31:0] enc_ls(input logic st, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [15:0] off);
        tawas_pkg::tawas_instr_u w;
        w = '0;
        w.ls.cls = tawas_pkg::CLS_LS;
        w.ls.store = st;
        w.ls.rd = rd;
        w.ls.ra = ra;
        w.ls.offset = off;
        return w;
    endfunction

    function automatic logic [31:0] enc_imm(input logic [2:0] rd, input logic [26:0] imm);
        tawas_pkg::tawas_instr_u w;
        w = '0;
        w.imm.cls = tawas_pkg::CLS_IMM;
        w.imm.rd = rd;
        w.imm.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] enc_br(input logic cond, input logic [23:0] target);
        tawas_pkg::tawas_instr_u w;
        w = '0;
        w.br.cls = tawas_pkg::CLS_BR;
        w.br.cond = cond;
        w.br.target = target;
        return w;
    endfunction

    function automatic void emit(input logic [31:0] word);
        imem[prog_pos] = word;
        prog_pos++;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {8'hd0, a, ~a, a ^ 8'h96};
    endfunction

    function automatic void build_program(input int kind, input int t);
        logic [2:0] rd;
        logic [2:0] sel;
        prog_pos = t * tawas_pkg::PC_STRIDE;
        emit(enc_imm(3'd7, t * 64));  // r7 is the thread's store block.
        case (kind)
            0: begin
                emit(enc_imm(3'd1, rand_bits(27)));
                emit(enc_imm(3'd2, rand_bits(27)));
            end
            1: begin
                emit(enc_imm(3'd1, rand_bits(27)));
                emit(enc_imm(3'd2, rand_bits(27)));
                for (int op = 0; op < 8; op++) begin
                    emit(enc_au(op, 3'd3, 3'd1, 3'd2));
                    emit(enc_ls(1'b1, 3'd3, 3'd7, op));
                end
            end
            2: begin
                emit(enc_imm(3'd1, rand_bits(27)));
                emit(enc_imm(3'd2, rand_bits(27)));
                emit(enc_ls(1'b1, 3'd1, 3'd7, 16'd5));
                emit(enc_ls(1'b0, 3'd4, 3'd7, 16'd5));
                emit(enc_au(tawas_pkg::OP_ADD, 3'd5, 3'd4, 3'd2));  // reads r4 right away.
                emit(enc_ls(1'b1, 3'd5, 3'd7, 16'd6));
            end
            3: begin
                emit(enc_imm(3'd1, rand_bits(27) | 32'd1));
                emit(enc_br(1'b0, prog_pos + 2));
                emit(enc_ls(1'b1, 3'd1, 3'd7, 16'd0));  // skipped.
                emit(enc_au(tawas_pkg::OP_SUB, 3'd2, 3'd1, 3'd1));
                emit(enc_br(1'b1, prog_pos + 2));         // taken on zero.
                emit(enc_ls(1'b1, 3'd1, 3'd7, 16'd1));
                emit(enc_au(tawas_pkg::OP_OR, 3'd3, 3'd1, 3'd1));
                emit(enc_br(1'b1, prog_pos + 2));         // falls through.
                emit(enc_ls(1'b1, 3'd3, 3'd7, 16'd2));
                emit(enc_ls(1'b1, 3'd2, 3'd7, 16'd3));
            end
            default: begin
                for (int r = 0; r < 7; r++)
                    emit(enc_imm(r, rand_bits(27)));
                for (int i = 0; i < 40; i++) begin
                    sel = rand_bits(3);
                    rd = rand_bits(3);
                    if (rd == 3'd7)
                        rd = 3'd6;
                    case (sel)
                        3'd4: emit(enc_imm(rd, rand_bits(27)));
                        3'd5: emit(enc_ls(1'b0, rd, 3'd7, rand_bits(6)));
                        3'd6: emit(enc_ls(1'b1, rand_bits(3), 3'd7, rand_bits(6)));
                        3'd7: emit(enc_br(1'b1, prog_pos + 2));
                        default: emit(enc_au(rand_bits(3), rd, rand_bits(3), rand_bits(3)));
                    endcase
                end
            end
        endcase
        emit(enc_br(1'b0, prog_pos));  // halt on a branch to itself.
    endfunction

    // ####################
    // ISA model that runs one thread at a time.
    function automatic void tawas_ref(input int t);
        logic [31:0]             r [8];
        logic                    z;
        logic                    done;
        int                      pc;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             res;
        logic [31:0]             addr;
        tawas_pkg::tawas_instr_u w;
        for (int i = 0; i < 8; i++)
            r[i] = '0;
        z = 1'b0;
        done = 1'b0;
        pc = t * tawas_pkg::PC_STRIDE;
        while (!done && pc_cnt[t] < MAX_PC) begin
            w = imem[pc];
            pc_list[t][pc_cnt[t]] = pc;
            pc_cnt[t]++;
            a = r[w.au.ra];
            b = r[w.au.rb];
            case (w.au.cls)
                tawas_pkg::CLS_AU: begin
                    case (w.au.opcode)
                        tawas_pkg::OP_ADD: res = a + b;
                        tawas_pkg::OP_SUB: res = a - b;
                        tawas_pkg::OP_AND: res = a & b;
                        tawas_pkg::OP_OR:  res = a | b;
                        tawas_pkg::OP_XOR: res = a ^ b;
                        tawas_pkg::OP_SHL: res = a << 1;
                        tawas_pkg::OP_SHR: res = a >> 1;
                        default:           res = a;
                    endcase
                    r[w.au.rd] = res;
                    z = (res == 32'd0);
                    pc++;
                end
                tawas_pkg::CLS_LS: begin
                    addr = r[w.ls.ra] + {{16{w.ls.offset[15]}}, w.ls.offset};
                    if (w.ls.store) begin
                        ref_mem[addr[7:0]] = r[w.ls.rd];
                        st_addr[t][st_cnt[t]] = addr;
                        st_data[t][st_cnt[t]] = r[w.ls.rd];
                        st_cnt[t]++;
                    end else begin
                        r[w.ls.rd] = ref_mem[addr[7:0]];
                    end
                    pc++;
                end
                tawas_pkg::CLS_IMM: begin
                    r[w.imm.rd] = {{5{w.imm.imm[26]}}, w.imm.imm};
                    pc++;
                end
                default: begin
                    if (!w.br.cond || z) begin
                        done = (w.br.target == pc);
                        pc = w.br.target;
                    end else begin
                        pc++;
                    end
                end
            endcase
        end
    endfunction

    function automatic logic all_done();
        logic d;
        d = 1'b1;
        for (int t = 0; t < tawas_pkg::THREADS; t++)
            d = d && halted[t] && (st_idx[t] == st_cnt[t]);
        return d;
    endfunction

    // ####################
    // both memories answer one cycle after the strobe.
    always @(negedge clk) begin
        if (ipend)
            idata <= imem[ipend_addr];
        ipend = rst_n && ics;
        ipend_addr = iaddr[9:0];
        if (dpend)
            din <= dmem[dpend_addr];  // read before this cycle's write.
        dpend = rst_n && dcs && !dwr;
        dpend_addr = daddr[7:0];
        if (rst_n && dcs && dwr)
            dmem[daddr[7:0]] = dout;
    end

    // fetch k of the rotation belongs to thread k mod 4.
    always @(negedge clk) begin
        if (!rst_n) begin
            fcount = 0;
            assert (!ics && !dcs && !dwr)
            else begin
                $display("%s: a bus strobe is high while reset is held", test_name);
                errors++;
            end
        end else if (ics) begin
            fth = fcount % tawas_pkg::THREADS;
            fcount++;
            assert (iaddr === pc_list[fth][pc_idx[fth]])
            else begin
                $display("** Error [%s] thread %0d fetch: expected %h, actual %h",
                         test_name, fth, pc_list[fth][pc_idx[fth]], iaddr);
                errors++;
            end
            if (pc_idx[fth] >= pc_cnt[fth] - 1)
                halted[fth] = 1'b1;
            else
                pc_idx[fth]++;
        end else begin
            assert (fcount == 0)
            else begin
                $display("%s: instruction fetch stopped after it had started", test_name);
                errors++;
            end
        end
    end

    // each thread stores into its own 64-word block.
    always @(negedge clk) begin
        if (rst_n && (dcs || dwr)) begin
            assert (!quiet_bus)
            else begin
                $display("%s: data bus used by a program without loads or stores", test_name);
                errors++;
            end
        end
        if (rst_n && dcs && dwr) begin
            sth = daddr[7:6];
            assert (st_idx[sth] < st_cnt[sth])
            else begin
                $display("%s: thread %0d stored more often than its program", test_name, sth);
                errors++;
            end
            if (st_idx[sth] < st_cnt[sth]) begin
                assert (daddr === st_addr[sth][st_idx[sth]])
                else begin
                    $display("** Error [%s] thread %0d store address: expected %h, actual %h",
                             test_name, sth, st_addr[sth][st_idx[sth]], daddr);
                    errors++;
                end
                assert (dout === st_data[sth][st_idx[sth]])
                else begin
                    $display("** Error [%s] thread %0d store data: expected %h, actual %h",
                             test_name, sth, st_data[sth][st_idx[sth]], dout);
                    errors++;
                end
                st_idx[sth]++;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            wd_cycles = 0;
        end else begin
            wd_cycles++;
            if (wd_cycles > limit) begin
                $display("%s: timeout, programs unfinished after %0d cycles", test_name, limit);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    task automatic run_test(input string name, input int kind);
        int base_errors;
        int longest;
        @(negedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        test_name = name;
        quiet_bus = (kind == 0);
        base_errors = errors;
        longest = 0;
        for (int i = 0; i < 1024; i++)
            imem[i] = enc_br(1'b0, i);  // every idle word is a halt.
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int t = 0; t < tawas_pkg::THREADS; t++) begin
            pc_cnt[t] = 0;
            pc_idx[t] = 0;
            halted[t] = 1'b0;
            st_cnt[t] = 0;
            st_idx[t] = 0;
            build_program(kind, t);
        end
        for (int t = 0; t < tawas_pkg::THREADS; t++) begin
            tawas_ref(t);
            if (pc_cnt[t] > longest)
                longest = pc_cnt[t];
        end
        limit = tawas_pkg::THREADS * (longest + 8) * 4;
        repeat (8) @(negedge clk);
        rst_n <= 1'b1;
        while (!all_done())
            @(posedge clk);
        repeat (2 * tawas_pkg::THREADS) @(posedge clk);  // stray stores show up here.
        tests++;
        if (errors == base_errors) begin
            $display("test %-12s passed", name);
        end else begin
            failed++;
            $display("test %-12s failed with %0d errors", name, errors - base_errors);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        idata = '0;
        din = '0;
        lfsr = 32'hfd71;
        errors = 0;
        tests = 0;
        failed = 0;
        limit = 100000;
        quiet_bus = 1'b0;
        ipend = 1'b0;
        dpend = 1'b0;
        fcount = 0;
        test_name = "idle";
        run_test("reset_fetch", 0);
        run_test("au_ops", 1);
        run_test("load_store", 2);
        run_test("branch", 3);
        run_test("isolation", 4);
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (failed == 0 && errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: flist.f
tawas_pkg.sv
tawas_fetch.sv
tawas_regfile.sv
tawas_au.sv
tawas_ls.sv
tawas.sv
tb_tawas.sv

// File: Bender.yml
package:
  name: tawas

sources:
  - tawas_pkg.sv
  - tawas_fetch.sv
  - tawas_regfile.sv
  - tawas_au.sv
  - tawas_ls.sv
  - tawas.sv
  - target: test
    files:
      - tb_tawas.sv
